// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= dcache_tb
FILELIST ?= dcache.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard rtl/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^Testbench passed$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== dcache.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_mem_pkg.sv
rtl/dcache_array_if.sv
rtl/dcache_ram.sv
rtl/dcache_arrays.sv
rtl/way_select.sv
rtl/uncached_store_queue.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

// ==== rtl/dcache.sv ====
// data cache top level
`timescale 1ns/1ps

module dcache
    import dcache_pkg::*, dcache_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        op,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        cached,
    output logic        busy,
    output logic        done,
    output logic [31:0] rdata,
    output logic        mem_rd_req,
    output logic [31:0] mem_rd_addr,
    output logic        mem_wr_req,
    output logic [31:0] mem_wr_addr,
    output line_t       mem_wr_line,
    input  logic        mem_rd_rdy,
    input  logic        mem_ret_valid,
    input  line_t       mem_ret_line,
    input  logic        mem_wr_rdy,
    input  logic        mem_wr_valid,
    output logic        unc_wr_req,
    output logic [31:0] unc_wr_addr,
    output logic [31:0] unc_wr_data,
    output logic [3:0]  unc_wr_wstrb,
    input  logic        unc_wr_rdy
);

    logic hit;
    way_t hit_way;
    way_t victim_way;
    logic victim_dirty;
    logic touch;
    tag_t req_tag;
    logic push;
    ustore_t push_entry;
    logic full;

    dcache_array_if arr_if ();

    dcache_ctrl u_ctrl (
        .clk, .rst, .req, .op, .addr, .wdata, .wstrb, .cached,
        .busy, .done, .rdata,
        .mem_rd_req, .mem_rd_addr, .mem_wr_req, .mem_wr_addr, .mem_wr_line,
        .mem_rd_rdy, .mem_ret_valid, .mem_ret_line, .mem_wr_rdy, .mem_wr_valid,
        .arr(arr_if.ctrl),
        .hit, .hit_way, .victim_way, .victim_dirty, .touch,
        .tag(req_tag), .push, .push_entry, .full
    );

    dcache_arrays u_arrays (
        .clk, .rst,
        .arr(arr_if.arrays)
    );

    way_select u_way_select (
        .clk, .rst, .tag(req_tag),
        .sel(arr_if.select),
        .touch, .hit, .hit_way, .victim_way, .victim_dirty
    );

    uncached_store_queue u_store_queue (
        .clk, .rst, .push, .push_entry, .full,
        .unc_wr_req, .unc_wr_addr, .unc_wr_data, .unc_wr_wstrb, .unc_wr_rdy
    );

endmodule

// ==== rtl/dcache_array_if.sv ====
// cache storage array interface
`timescale 1ns/1ps
`include "dcache_config.svh"

interface dcache_array_if
    import dcache_pkg::*, dcache_mem_pkg::*;
();

    index_t index;

    logic [`DCACHE_WAYS-1:0] tagv_we;
    tagv_t tagv_wdata;
    logic [`DCACHE_WAYS-1:0] dirty_we;
    logic dirty_wdata;
    logic [`DCACHE_WAYS-1:0] line_we;
    logic [`DCACHE_LINE_WORDS-1:0] line_wmask;
    line_t line_wdata;

    // read data, one cycle after index
    tagv_t [`DCACHE_WAYS-1:0] tagv_rdata;
    logic [`DCACHE_WAYS-1:0] dirty_rdata;
    line_t [`DCACHE_WAYS-1:0] line_rdata;

    // low while valid and dirty bits are swept after reset
    logic init_done;

    modport ctrl (
        output index, tagv_we, tagv_wdata, dirty_we, dirty_wdata,
        output line_we, line_wmask, line_wdata,
        input  tagv_rdata, line_rdata, init_done
    );

    modport arrays (
        input  index, tagv_we, tagv_wdata, dirty_we, dirty_wdata,
        input  line_we, line_wmask, line_wdata,
        output tagv_rdata, dirty_rdata, line_rdata, init_done
    );

    modport select (
        input index, tagv_rdata, dirty_rdata
    );

endinterface

// ==== rtl/dcache_arrays.sv ====
// per way tag, dirty and line storage
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_arrays
    import dcache_pkg::*, dcache_mem_pkg::*;
(
    input logic clk,
    input logic rst,
    dcache_array_if.arrays arr
);

    index_t sweep_idx;
    index_t ram_addr;

    // clear one set per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_idx <= '0;
            arr.init_done <= 1'b0;
        end else if (!arr.init_done) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == index_t'(`DCACHE_SETS - 1)) begin
                arr.init_done <= 1'b1;
            end
        end
    end

    assign ram_addr = arr.init_done ? arr.index : sweep_idx;

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_ram #(
            .payload_t(tagv_t),
            .DEPTH(`DCACHE_SETS)
        ) u_tagv (
            .clk(clk),
            .we(arr.tagv_we[w] || !arr.init_done),
            .wmask(1'b1),
            .addr(ram_addr),
            .wdata(arr.init_done ? arr.tagv_wdata : tagv_t'('0)),
            .rdata(arr.tagv_rdata[w])
        );

        dcache_ram #(
            .payload_t(logic),
            .DEPTH(`DCACHE_SETS)
        ) u_dirty (
            .clk(clk),
            .we(arr.dirty_we[w] || !arr.init_done),
            .wmask(1'b1),
            .addr(ram_addr),
            .wdata(arr.dirty_wdata && arr.init_done),
            .rdata(arr.dirty_rdata[w])
        );

        // line data needs no clearing
        dcache_ram #(
            .payload_t(line_t),
            .DEPTH(`DCACHE_SETS),
            .MASK_W(`DCACHE_LINE_WORDS)
        ) u_line (
            .clk(clk),
            .we(arr.line_we[w] && arr.init_done),
            .wmask(arr.line_wmask),
            .addr(ram_addr),
            .wdata(arr.line_wdata),
            .rdata(arr.line_rdata[w])
        );
    end

endmodule

// ==== rtl/dcache_config.svh ====
// data cache configuration
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cache geometry
`define DCACHE_WAYS 2
`define DCACHE_SETS 16
`define DCACHE_LINE_WORDS 4

// entries in the uncached store queue
`define DCACHE_QUEUE_DEPTH 4

`endif

// ==== rtl/dcache_ctrl.sv ====
// data cache control fsm
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl
    import dcache_pkg::*, dcache_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        op,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        cached,
    output logic        busy,
    output logic        done,
    output logic [31:0] rdata,
    output logic        mem_rd_req,
    output logic [31:0] mem_rd_addr,
    output logic        mem_wr_req,
    output logic [31:0] mem_wr_addr,
    output line_t       mem_wr_line,
    input  logic        mem_rd_rdy,
    input  logic        mem_ret_valid,
    input  line_t       mem_ret_line,
    input  logic        mem_wr_rdy,
    input  logic        mem_wr_valid,
    dcache_array_if.ctrl arr,
    input  logic        hit,
    input  way_t        hit_way,
    input  way_t        victim_way,
    input  logic        victim_dirty,
    output logic        touch,
    output tag_t        tag,
    output logic        push,
    output ustore_t     push_entry,
    input  logic        full
);

    ctrl_state_t state, state_next;
    addr_t cpu_addr;
    addr_t req_addr;
    logic req_op;
    logic req_cached;
    logic [31:0] req_wdata;
    logic [3:0] req_wstrb;
    logic accept;
    logic unc_store;
    logic [31:0] hit_word;
    logic [31:0] merged_word;
    tagv_t victim_tagv;

    assign cpu_addr = addr;
    assign busy = (state != LOOKUP) || !arr.init_done;
    assign accept = req && !busy;
    assign unc_store = req_op && !req_cached;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= cpu_addr;
            req_op <= op;
            req_cached <= cached;
            req_wdata <= wdata;
            req_wstrb <= wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: if (accept) state_next = cached ? COMPARE : RESPOND;
            COMPARE: begin
                if (hit) begin
                    state_next = RESPOND;
                end else begin
                    state_next = victim_dirty ? WRITEBACK_REQ : REFILL_REQ;
                end
            end
            WRITEBACK_REQ: if (mem_wr_rdy) state_next = WRITEBACK_WAIT;
            WRITEBACK_WAIT: if (mem_wr_valid) state_next = REFILL_REQ;
            REFILL_REQ: if (mem_rd_rdy) state_next = REFILL_WAIT;
            REFILL_WAIT: if (mem_ret_valid) state_next = REPLAY;
            // array read of the new line, then compare again
            REPLAY: state_next = COMPARE;
            RESPOND: if (!(unc_store && full)) state_next = LOOKUP;
            default: state_next = LOOKUP;
        endcase
    end

    // lookup reads with the incoming address, later states with the held one
    assign arr.index = (state == LOOKUP) ? cpu_addr.index : req_addr.index;

    assign hit_word = arr.line_rdata[hit_way][req_addr.word];
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged_word[b*8 +: 8] = req_wstrb[b] ? req_wdata[b*8 +: 8] : hit_word[b*8 +: 8];
        end
    end

    always_comb begin
        arr.tagv_we = '0;
        arr.dirty_we = '0;
        arr.line_we = '0;
        arr.tagv_wdata = tagv_t'{1'b1, req_addr.tag};
        arr.dirty_wdata = 1'b0;
        arr.line_wmask = '1;
        arr.line_wdata = mem_ret_line;
        if (state == COMPARE && hit && req_op) begin
            // store hit writes only the addressed word
            arr.dirty_we[hit_way] = 1'b1;
            arr.dirty_wdata = 1'b1;
            arr.line_we[hit_way] = 1'b1;
            arr.line_wmask = '0;
            arr.line_wmask[req_addr.word] = 1'b1;
            arr.line_wdata = {`DCACHE_LINE_WORDS{merged_word}};
        end else if (state == REFILL_WAIT && mem_ret_valid) begin
            arr.tagv_we[victim_way] = 1'b1;
            arr.dirty_we[victim_way] = 1'b1;
            arr.line_we[victim_way] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == COMPARE && hit) begin
            rdata <= hit_word;
        end
    end

    assign touch = (state == COMPARE) && hit;
    assign tag = req_addr.tag;
    assign done = (state == RESPOND) && !(unc_store && full);
    assign push = (state == RESPOND) && unc_store && !full;
    assign push_entry = ustore_t'{req_addr, req_wdata, req_wstrb};

    // victim line stays on the read port while its index is held
    assign victim_tagv = arr.tagv_rdata[victim_way];
    assign mem_wr_req = (state == WRITEBACK_REQ);
    assign mem_wr_addr = {victim_tagv.tag, req_addr.index, {(WORD_SEL_W + 2){1'b0}}};
    assign mem_wr_line = arr.line_rdata[victim_way];
    assign mem_rd_req = (state == REFILL_REQ);
    assign mem_rd_addr = {req_addr.tag, req_addr.index, {(WORD_SEL_W + 2){1'b0}}};

endmodule

// ==== rtl/dcache_mem_pkg.sv ====
// memory side line and store types
`include "dcache_config.svh"

package dcache_mem_pkg;

    // word 0 sits in the low bits
    typedef logic [`DCACHE_LINE_WORDS-1:0][31:0] line_t;

    // one queued uncached store
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  wstrb;
    } ustore_t;

endpackage

// ==== rtl/dcache_pkg.sv ====
// data cache address and control types
`include "dcache_config.svh"

package dcache_pkg;

    localparam int INDEX_W = $clog2(`DCACHE_SETS);
    localparam int WORD_SEL_W = $clog2(`DCACHE_LINE_WORDS);
    // byte offset inside a word is always two bits
    localparam int TAG_W = 32 - INDEX_W - WORD_SEL_W - 2;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    typedef struct packed {
        tag_t      tag;
        index_t    index;
        word_sel_t word;
        logic [1:0] byte_sel;
    } addr_t;

    // one tag array entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef enum logic [2:0] {
        LOOKUP,
        COMPARE,
        WRITEBACK_REQ,
        WRITEBACK_WAIT,
        REFILL_REQ,
        REFILL_WAIT,
        REPLAY,
        RESPOND
    } ctrl_state_t;

endpackage

// ==== rtl/dcache_ram.sv ====
// single port synchronous ram
`timescale 1ns/1ps

module dcache_ram #(
    parameter type payload_t = logic [31:0],
    parameter int DEPTH = 16,
    parameter int MASK_W = 1
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [MASK_W-1:0]        wmask,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    localparam int W = $bits(payload_t);
    localparam int SLICE = W / MASK_W;

    logic [W-1:0] mem [DEPTH];
    logic [W-1:0] wbits;

    assign wbits = wdata;

    // read returns the old contents on a write to the same entry
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < MASK_W; i++) begin
                if (wmask[i]) begin
                    mem[addr][i*SLICE +: SLICE] <= wbits[i*SLICE +: SLICE];
                end
            end
        end
        rdata <= payload_t'(mem[addr]);
    end

endmodule

// ==== rtl/uncached_store_queue.sv ====
// uncached store fifo
`timescale 1ns/1ps
`include "dcache_config.svh"

module uncached_store_queue
    import dcache_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  ustore_t     push_entry,
    output logic        full,
    output logic        unc_wr_req,
    output logic [31:0] unc_wr_addr,
    output logic [31:0] unc_wr_data,
    output logic [3:0]  unc_wr_wstrb,
    input  logic        unc_wr_rdy
);

    localparam int DEPTH = `DCACHE_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    ustore_t entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic do_push;
    logic pop;

    assign full = (count == (PTR_W+1)'(DEPTH));
    assign unc_wr_req = (count != '0);
    assign do_push = push && !full;
    assign pop = unc_wr_req && unc_wr_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    // head entry stays on the port until taken
    assign unc_wr_addr = entries[rd_ptr].addr;
    assign unc_wr_data = entries[rd_ptr].data;
    assign unc_wr_wstrb = entries[rd_ptr].wstrb;

endmodule

// ==== rtl/way_select.sv ====
// hit detection and lru victim choice
`timescale 1ns/1ps
`include "dcache_config.svh"

module way_select
    import dcache_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  tag_t tag,
    dcache_array_if.select sel,
    input  logic touch,
    output logic hit,
    output way_t hit_way,
    output way_t victim_way,
    output logic victim_dirty
);

    // per set, the way that was used least recently
    logic [`DCACHE_SETS-1:0] lru;

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (sel.tagv_rdata[w].valid && sel.tagv_rdata[w].tag == tag) begin
                hit = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign victim_way = way_t'(lru[sel.index]);
    assign victim_dirty = sel.dirty_rdata[victim_way];

    // two ways, so the other way becomes lru
    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
        end else if (touch) begin
            lru[sel.index] <= (hit_way == '0);
        end
    end

endmodule

// ==== sim/dcache_checker.sv ====
// data cache result checker
`timescale 1ns/1ps

module dcache_checker
    import dcache_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        op,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        cached,
    input  logic        busy,
    input  logic        done,
    input  logic [31:0] rdata,
    input  logic        mem_rd_req,
    input  logic [31:0] mem_rd_addr,
    input  logic        mem_wr_req,
    input  logic [31:0] mem_wr_addr,
    input  line_t       mem_wr_line,
    input  logic        mem_wr_rdy,
    input  logic        unc_wr_req,
    input  logic [31:0] unc_wr_addr,
    input  logic [31:0] unc_wr_data,
    input  logic [3:0]  unc_wr_wstrb,
    input  logic        unc_wr_rdy,
    input  logic [1:0]  exp_lat,
    input  logic        exp_wb,
    input  logic [31:0] exp_wb_addr,
    output int          errors,
    output int          checks,
    output int          unc_pending
);

    int err_cnt = 0;
    int chk_cnt = 0;
    int pend_cnt = 0;
    int cycle = 0;
    int accept_cycle;
    logic cur_op, cur_cached, cur_wb, wb_seen, rd_seen;
    logic in_flight = 1'b0;
    logic done_seen = 1'b0;
    logic [1:0] cur_lat;
    logic [31:0] cur_addr, cur_wb_addr, exp_word;
    logic [31:0] shadow [logic [31:0]];
    ustore_t unc_exp [$];

    assign errors = err_cnt;
    assign checks = chk_cnt;
    assign unc_pending = pend_cnt;

    // same fill pattern as the line memory model
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_9600;
    endfunction

    function automatic logic [31:0] read_shadow(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        return shadow.exists(wa) ? shadow[wa] : fill_word(wa);
    endfunction

    task automatic report(input string msg);
        err_cnt++;
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        chk_cnt++;
        if (got !== exp) begin
            report($sformatf("%s got %08h expected %08h", what, got, exp));
        end
    endtask

    always @(posedge clk) begin
        logic [31:0] w;
        ustore_t head;
        if (rst) begin
            if (cycle > 0 && (done | mem_rd_req | mem_wr_req | unc_wr_req) !== 1'b0) begin
                report("strobe active during reset");
            end
        end else begin
            // busy covers everything from acceptance through done
            if (in_flight && busy !== 1'b1) begin
                report("busy low while a request is in flight");
            end
            if (done_seen && busy !== 1'b0) begin
                report("busy still high after done");
            end
            if (req && !busy) begin
                cur_op = op;
                cur_addr = addr;
                cur_cached = cached;
                cur_lat = exp_lat;
                cur_wb = exp_wb;
                cur_wb_addr = exp_wb_addr;
                accept_cycle = cycle;
                wb_seen = 1'b0;
                rd_seen = 1'b0;
                in_flight = 1'b1;
                if (op && cached) begin
                    w = read_shadow(addr);
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            w[b*8 +: 8] = wdata[b*8 +: 8];
                        end
                    end
                    shadow[{addr[31:2], 2'b00}] = w;
                end else if (op) begin
                    unc_exp.push_back('{addr, wdata, wstrb});
                end else begin
                    exp_word = read_shadow(addr);
                end
            end
            if (mem_rd_req && !rd_seen) begin
                rd_seen = 1'b1;
                if (!cur_cached || cur_lat == 2'd2) begin
                    report("line read on a request that should not miss");
                end
                compare_word(mem_rd_addr, {cur_addr[31:4], 4'h0}, "refill address");
            end
            if (mem_wr_req && mem_wr_rdy) begin
                wb_seen = 1'b1;
                if (!cur_wb) begin
                    report("unexpected write-back");
                end
                compare_word(mem_wr_addr, cur_wb_addr, "write-back address");
                for (int i = 0; i < 4; i++) begin
                    compare_word(mem_wr_line[i], read_shadow(mem_wr_addr + 32'(i * 4)),
                                 "write-back data");
                end
            end
            if (done) begin
                chk_cnt++;
                if (!in_flight) begin
                    report("done without an accepted request");
                end
                in_flight = 1'b0;
                if (cur_lat != 2'd0 && cycle - accept_cycle != int'(cur_lat)) begin
                    report($sformatf("done after %0d cycles, expected %0d",
                                     cycle - accept_cycle, cur_lat));
                end
                // cached rows without a fixed latency are misses
                if (cur_cached && cur_lat == 2'd0 && !rd_seen) begin
                    report("expected line read did not happen");
                end
                if (cur_wb && !wb_seen) begin
                    report("expected write-back did not happen");
                end
                if (!cur_op) begin
                    compare_word(rdata, exp_word, "load data");
                end
            end
            done_seen = (done === 1'b1);
            if (unc_wr_req && unc_wr_rdy) begin
                if (unc_exp.size() == 0) begin
                    report("uncached store that was never issued");
                end else begin
                    head = unc_exp.pop_front();
                    compare_word(unc_wr_addr, head.addr, "uncached address");
                    compare_word(unc_wr_data, head.data, "uncached data");
                    compare_word({28'h0, unc_wr_wstrb}, {28'h0, head.wstrb}, "uncached strobes");
                end
            end
        end
        pend_cnt = unc_exp.size();
        cycle++;
    end

endmodule

// ==== sim/dcache_tb.sv ====
// data cache testbench
`timescale 1ns/1ps

module dcache_tb
    import dcache_mem_pkg::*;
();

    localparam int HOLD_CYCLES = 40;
    // worst case miss with write-back and slow memory, plus slack
    localparam int MISS_CYCLES = 40;

    typedef struct packed {
        logic        op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        cached;
        logic [1:0]  lat;
        logic        wb;
        logic [31:0] wb_addr;
        logic        hold;
    } row_t;

    logic clk = 1'b0;
    logic rst, req, op, cached, busy, done;
    logic [31:0] addr, wdata, rdata;
    logic [3:0] wstrb;
    logic mem_rd_req, mem_rd_rdy, mem_ret_valid, mem_wr_req, mem_wr_rdy, mem_wr_valid;
    logic [31:0] mem_rd_addr, mem_wr_addr;
    line_t mem_wr_line, mem_ret_line;
    logic unc_wr_req, unc_wr_rdy;
    logic [31:0] unc_wr_addr, unc_wr_data;
    logic [3:0] unc_wr_wstrb;
    logic [1:0] exp_lat;
    logic exp_wb;
    logic [31:0] exp_wb_addr;
    logic unc_hold;
    int errors, checks, unc_pending;

    row_t rows [$];
    logic [7:0] lfsr = 8'd86;
    logic [31:0] line_mem [logic [31:0]];

    dcache uut (.*);
    dcache_checker chk (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_9600;
    endfunction

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic lfsr_bit();
        lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        return lfsr[0];
    endfunction

    function automatic int pick_delay();
        logic [1:0] d;
        d[0] = lfsr_bit();
        d[1] = lfsr_bit();
        return int'(d);
    endfunction

    task automatic add_row(input logic o, input logic [31:0] a, input logic [31:0] d,
                           input logic [3:0] s, input logic c, input logic [1:0] l,
                           input logic w, input logic [31:0] wa, input logic h);
        rows.push_back('{o, a, d, s, c, l, w, wa, h});
    endtask

    // line read model
    initial forever begin
        logic [31:0] a;
        @(negedge clk);
        if (mem_rd_req) begin
            a = mem_rd_addr;
            repeat (pick_delay()) @(negedge clk);
            mem_rd_rdy = 1'b1;
            @(negedge clk);
            mem_rd_rdy = 1'b0;
            repeat (pick_delay()) @(negedge clk);
            for (int i = 0; i < 4; i++) begin
                mem_ret_line[i] = line_mem.exists(a + 32'(i * 4)) ?
                    line_mem[a + 32'(i * 4)] : fill_word(a + 32'(i * 4));
            end
            mem_ret_valid = 1'b1;
            @(negedge clk);
            mem_ret_valid = 1'b0;
        end
    end

    // write-back model
    initial forever begin
        @(negedge clk);
        if (mem_wr_req) begin
            repeat (pick_delay()) @(negedge clk);
            for (int i = 0; i < 4; i++) begin
                line_mem[mem_wr_addr + 32'(i * 4)] = mem_wr_line[i];
            end
            mem_wr_rdy = 1'b1;
            @(negedge clk);
            mem_wr_rdy = 1'b0;
            repeat (pick_delay()) @(negedge clk);
            mem_wr_valid = 1'b1;
            @(negedge clk);
            mem_wr_valid = 1'b0;
        end
    end

    // uncached port, stalled for a while once a hold row is issued
    initial forever begin
        @(negedge clk);
        unc_wr_rdy = unc_hold ? 1'b0 : lfsr_bit();
    end

    initial forever begin
        wait (unc_hold === 1'b1);
        repeat (HOLD_CYCLES) @(negedge clk);
        unc_hold = 1'b0;
    end

    initial begin
        #1;
        #((rows.size() * MISS_CYCLES + HOLD_CYCLES + 200) * 40);
        $display("Timeout: the run did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        {rst, req, op, cached, addr, wdata, wstrb} = {1'b1, 71'h0};
        {mem_rd_rdy, mem_ret_valid, mem_wr_rdy, mem_wr_valid, unc_wr_rdy} = '0;
        mem_ret_line = '0;
        {exp_lat, exp_wb, exp_wb_addr, unc_hold} = '0;
        // set 0: cold miss, hit, partial store, merged load
        add_row(0, 32'h0000_1000, 0, 0, 1, 0, 0, 0, 0);
        add_row(0, 32'h0000_1008, 0, 0, 1, 2, 0, 0, 0);
        add_row(1, 32'h0000_1004, 32'haabb_ccdd, 4'b0101, 1, 2, 0, 0, 0);
        add_row(0, 32'h0000_1004, 0, 0, 1, 2, 0, 0, 0);
        // set 1: A, B, C evicts dirty A
        add_row(1, 32'h0000_2010, 32'h1111_2222, 4'b1111, 1, 0, 0, 0, 0);
        add_row(0, 32'h0000_3010, 0, 0, 1, 0, 0, 0, 0);
        add_row(0, 32'h0000_4014, 0, 0, 1, 0, 1, 32'h0000_2010, 0);
        add_row(0, 32'h0000_4014, 0, 0, 1, 2, 0, 0, 0);
        // set 2: A, B, A, C evicts dirty B
        add_row(1, 32'h0000_5020, 32'h3333_4444, 4'b0011, 1, 0, 0, 0, 0);
        add_row(1, 32'h0000_6024, 32'h5555_6666, 4'b1100, 1, 0, 0, 0, 0);
        add_row(0, 32'h0000_5028, 0, 0, 1, 2, 0, 0, 0);
        add_row(0, 32'h0000_7020, 0, 0, 1, 0, 1, 32'h0000_6020, 0);
        for (int i = 0; i < 3; i++) begin
            add_row(1, 32'h8000_0100 + 32'(i * 4), 32'hd000_0000 + 32'(i), 4'(i + 1),
                    0, 1, 0, 0, 0);
        end
        // more stores than queue entries while the port is stalled
        for (int i = 0; i < 6; i++) begin
            add_row(1, 32'h8000_0200 + 32'(i * 4), 32'hc0de_0000 + 32'(i), 4'(i + 1),
                    0, 0, 0, 0, i == 0);
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            while (busy) @(negedge clk);
            {op, addr, wdata, wstrb, cached} = {rows[i].op, rows[i].addr, rows[i].wdata,
                                                rows[i].wstrb, rows[i].cached};
            {exp_lat, exp_wb, exp_wb_addr} = {rows[i].lat, rows[i].wb, rows[i].wb_addr};
            if (rows[i].hold) begin
                unc_hold = 1'b1;
            end
            req = 1'b1;
            @(negedge clk);
            req = 1'b0;
        end
        while (busy || unc_wr_req || unc_hold) @(negedge clk);
        repeat (4) @(negedge clk);
        if (unc_pending != 0) begin
            $display("%0d uncached stores never reached the port", unc_pending);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0 && unc_pending == 0 && checks > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
